//--- hdl/hps_link_pkg.sv
package hps_link_pkg;

	//////////////////////////////////////////////////////////////////////////////
	// widths
	//////////////////////////////////////////////////////////////////////////////

	localparam int io_word_w    = 16;
	localparam int joy_w        = 32;
	localparam int status_w     = 64;
	localparam int ioctl_addr_w = 27;
	localparam int ps2_key_w    = 11;
	// data word counter, saturating
	localparam int word_idx_w   = 10;

	// 16-bit transfers, so the address moves by two bytes per word
	localparam logic [ioctl_addr_w-1:0] ioctl_addr_step = 27'd2;

	//////////////////////////////////////////////////////////////////////////////
	// keyboard decode values
	//////////////////////////////////////////////////////////////////////////////

	localparam logic [7:0]  ps2_skip_ctl          = 8'hff;
	localparam logic [7:0]  key_break             = 8'hf0;
	localparam logic [7:0]  key_ext               = 8'he0;
	localparam logic [31:0] key_prnscr_make       = 32'he012e07c;
	localparam logic [31:0] key_prnscr_break      = 32'h7ce0f012;
	localparam logic [31:0] key_pause_make        = 32'hf014f077;
	localparam logic [9:0]  key_prnscr_code_make  = 10'h37c;
	localparam logic [9:0]  key_prnscr_code_break = 10'h17c;
	localparam logic [9:0]  key_pause_code        = 10'h377;

	// upper nibble of the status request reply
	localparam logic [3:0]  status_req_tag        = 4'ha;

	//////////////////////////////////////////////////////////////////////////////
	// command codes
	//////////////////////////////////////////////////////////////////////////////

	localparam logic [7:0] cmd_cfg        = 8'h01;
	localparam logic [7:0] cmd_joy0       = 8'h02;
	localparam logic [7:0] cmd_joy1       = 8'h03;
	localparam logic [7:0] cmd_kbd        = 8'h05;
	localparam logic [7:0] cmd_joy2       = 8'h10;
	localparam logic [7:0] cmd_joy3       = 8'h11;
	localparam logic [7:0] cmd_status     = 8'h1e;
	localparam logic [7:0] cmd_status_req = 8'h29;
	localparam logic [7:0] cmd_menumask   = 8'h2e;
	localparam logic [7:0] cmd_file_tx    = 8'h53;
	localparam logic [7:0] cmd_file_dat   = 8'h54;
	localparam logic [7:0] cmd_file_index = 8'h55;
	localparam logic [7:0] cmd_file_info  = 8'h56;

	// host word, seen whole or as a keyboard control/data pair
	typedef union packed {
		logic [io_word_w-1:0] raw;
		struct packed {
			logic [7:0] ctl;
			logic [7:0] data;
		} ps2;
	} io_word_u;

endpackage

//--- hdl/io_frame_if.sv
`timescale 1ns/1ps

interface io_frame_if import hps_link_pkg::*; ();

	// command word latched at the start of the frame
	logic [io_word_w-1:0]  cmd;
	// word on the host bus right now
	io_word_u              word;
	// 1 for the first data word
	logic [word_idx_w-1:0] word_idx;
	logic                  cmd_stb;
	logic                  data_stb;
	logic                  frame_end;

	modport framer (
		output cmd,
		output word,
		output word_idx,
		output cmd_stb,
		output data_stb,
		output frame_end
	);

	modport sink (
		input  cmd,
		input  word,
		input  word_idx,
		input  cmd_stb,
		input  data_stb,
		input  frame_end
	);

endinterface

//--- hdl/io_framer.sv
`timescale 1ns/1ps

module io_framer import hps_link_pkg::*; (
	input  logic       clk_sys,
	input  logic       reset,
	input  logic       io_enable,
	input  logic       io_strobe,
	input  io_word_u   io_din,
	io_frame_if.framer frame
);

	logic [io_word_w-1:0]  cmd_q;
	logic [word_idx_w-1:0] word_cnt;
	logic                  frame_active;
	logic                  frame_end_q;
	logic                  word_stb;

	assign word_stb = io_enable & io_strobe;

	////////////////////////////////////////////////////////////////////////////
	// frame tracking
	////////////////////////////////////////////////////////////////////////////

	always_ff @(posedge clk_sys or posedge reset) begin
		if (reset) begin
			cmd_q        <= '0;
			word_cnt     <= '0;
			frame_active <= 1'b0;
			frame_end_q  <= 1'b0;
		end else begin
			frame_active <= io_enable;
			// one pulse on the clock after enable drops
			frame_end_q  <= frame_active & ~io_enable;

			if (!io_enable) begin
				word_cnt <= '0;
			end else if (io_strobe) begin
				// first word of a frame is the command
				if (word_cnt == '0)
					cmd_q <= io_din.raw;
				if (~&word_cnt)
					word_cnt <= word_cnt + 1'b1;
			end
		end
	end

	assign frame.cmd       = cmd_q;
	assign frame.word      = io_din;
	assign frame.word_idx  = word_cnt;
	assign frame.cmd_stb   = word_stb & (word_cnt == '0);
	assign frame.data_stb  = word_stb & (word_cnt != '0);
	assign frame.frame_end = frame_end_q;

	////////////////////////////////////////////////////////////////////////////
	// checks
	////////////////////////////////////////////////////////////////////////////

	a_stb_exclusive: assert property (
		@(posedge clk_sys) disable iff (reset)
		!(frame.cmd_stb && frame.data_stb)
	);

	// once saturated the counter stays put until the frame is over
	a_idx_no_wrap: assert property (
		@(posedge clk_sys) disable iff (reset)
		(io_enable && (&word_cnt)) |=> (&word_cnt)
	);

endmodule

//--- hdl/host_regs.sv
`timescale 1ns/1ps

module host_regs import hps_link_pkg::*; (
	input  logic                 clk_sys,
	input  logic                 reset,
	io_frame_if.sink             frame,
	input  logic [status_w-1:0]  status_in,
	input  logic                 status_set,
	input  logic [io_word_w-1:0] status_menumask,
	output logic [io_word_w-1:0] io_dout,
	output logic [1:0]           buttons,
	output logic                 forced_scandoubler,
	output logic                 direct_video,
	output logic [joy_w-1:0]     joystick_0,
	output logic [joy_w-1:0]     joystick_1,
	output logic [joy_w-1:0]     joystick_2,
	output logic [joy_w-1:0]     joystick_3,
	output logic [status_w-1:0]  status
);

	logic [io_word_w-1:0]  cfg;
	logic [3:0][joy_w-1:0] joy;
	logic                  joy_hit;
	logic [1:0]            joy_sel;
	logic                  old_status_set;
	logic [3:0]            status_cnt;
	logic [status_w-1:0]   status_req;
	logic                  quad_word;
	logic [1:0]            quad_slot;

	// config word bits
	assign buttons            = cfg[1:0];
	assign forced_scandoubler = cfg[4];
	assign direct_video       = cfg[10];

	assign joystick_0 = joy[0];
	assign joystick_1 = joy[1];
	assign joystick_2 = joy[2];
	assign joystick_3 = joy[3];

	// 64-bit values move as four 16-bit words, low word first
	assign quad_word = (frame.word_idx <= 4);
	assign quad_slot = frame.word_idx[1:0] - 2'd1;

	// which joystick a command addresses
	always_comb begin
		joy_hit = 1'b1;
		joy_sel = 2'd0;
		case (frame.cmd)
			cmd_joy0: joy_sel = 2'd0;
			cmd_joy1: joy_sel = 2'd1;
			cmd_joy2: joy_sel = 2'd2;
			cmd_joy3: joy_sel = 2'd3;
			default:  joy_hit = 1'b0;
		endcase
	end

	////////////////////////////////////////////////////////////////////////////
	// registers and readback
	////////////////////////////////////////////////////////////////////////////

	always_ff @(posedge clk_sys or posedge reset) begin
		if (reset) begin
			cfg            <= '0;
			joy            <= '0;
			status         <= '0;
			old_status_set <= 1'b0;
			status_cnt     <= '0;
			status_req     <= '0;
			io_dout        <= '0;
		end else begin
			// core asks the host to take a new status value
			old_status_set <= status_set;
			if (status_set && !old_status_set) begin
				status_cnt <= status_cnt + 1'b1;
				status_req <= status_in;
			end

			if (frame.frame_end)
				io_dout <= '0;

			if (frame.cmd_stb) begin
				io_dout <= '0;
				if (frame.word.raw == cmd_status_req)
					io_dout <= {8'h00, status_req_tag, status_cnt};
			end

			if (frame.data_stb) begin
				io_dout <= '0;

				if (joy_hit) begin
					if (frame.word_idx == 1)
						joy[joy_sel][15:0] <= frame.word.raw;
					else
						joy[joy_sel][31:16] <= frame.word.raw;
				end

				case (frame.cmd)
					cmd_cfg: cfg <= frame.word.raw;

					cmd_status:
						if (quad_word)
							status[{quad_slot, 4'b0000} +: 16] <= frame.word.raw;

					cmd_status_req:
						if (quad_word)
							io_dout <= status_req[{quad_slot, 4'b0000} +: 16];

					cmd_menumask:
						if (frame.word_idx == 1)
							io_dout <= status_menumask;

					default: ;
				endcase
			end
		end
	end

	// nothing is driven back to the host between frames
	a_dout_idle: assert property (
		@(posedge clk_sys) disable iff (reset)
		frame.frame_end |=> (io_dout == '0) until frame.cmd_stb
	);

endmodule

//--- hdl/ps2_key_capture.sv
`timescale 1ns/1ps

module ps2_key_capture import hps_link_pkg::*; (
	input  logic                 clk_sys,
	input  logic                 reset,
	io_frame_if.sink             frame,
	output logic [ps2_key_w-1:0] ps2_key
);

	// last four scan bytes, newest in the low byte
	logic [31:0] key_raw;
	logic        kbd_frame;
	logic        skip;
	logic        pressed;
	logic        extended;
	logic [9:0]  key_code;

	assign pressed  = (key_raw[15:8] != key_break);
	assign extended = pressed ? (key_raw[15:8] == key_ext) : (key_raw[23:16] == key_ext);

	// print screen and pause do not fit the prefix rule
	always_comb begin
		case (key_raw)
			key_prnscr_make:  key_code = key_prnscr_code_make;
			key_prnscr_break: key_code = key_prnscr_code_break;
			key_pause_make:   key_code = key_pause_code;
			default:          key_code = {pressed, extended, key_raw[7:0]};
		endcase
	end

	////////////////////////////////////////////////////////////////////////////
	// scan byte collection
	////////////////////////////////////////////////////////////////////////////

	always_ff @(posedge clk_sys or posedge reset) begin
		if (reset) begin
			key_raw   <= '0;
			kbd_frame <= 1'b0;
			skip      <= 1'b0;
			ps2_key   <= '0;
		end else begin
			if (frame.cmd_stb) begin
				kbd_frame <= (frame.word.raw == cmd_kbd);
				skip      <= 1'b0;
				if (frame.word.raw == cmd_kbd)
					key_raw <= '0;
			end

			if (frame.data_stb && kbd_frame) begin
				if (frame.word.ps2.ctl == ps2_skip_ctl)
					skip <= 1'b1;
				else if (!skip)
					key_raw <= {key_raw[23:0], frame.word.ps2.data};
			end

			// bit 10 flips once per accepted event
			if (frame.frame_end) begin
				kbd_frame <= 1'b0;
				skip      <= 1'b0;
				if (kbd_frame && !skip)
					ps2_key <= {~ps2_key[10], key_code};
			end
		end
	end

endmodule

//--- hdl/file_loader.sv
`timescale 1ns/1ps

module file_loader import hps_link_pkg::*; (
	input  logic                    clk_sys,
	input  logic                    reset,
	io_frame_if.sink                frame,
	output logic                    ioctl_download,
	output logic [7:0]              ioctl_index,
	output logic                    ioctl_wr,
	output logic [ioctl_addr_w-1:0] ioctl_addr,
	output logic [io_word_w-1:0]    ioctl_dout,
	output logic [31:0]             ioctl_file_ext
);

	// running address of the next data word
	logic [ioctl_addr_w-1:0] addr;
	// write waits one cycle behind the data
	logic                    wr_pend;

	////////////////////////////////////////////////////////////////////////////
	// download control
	////////////////////////////////////////////////////////////////////////////

	always_ff @(posedge clk_sys or posedge reset) begin
		if (reset) begin
			ioctl_download <= 1'b0;
			ioctl_index    <= '0;
			ioctl_wr       <= 1'b0;
			ioctl_addr     <= '0;
			ioctl_dout     <= '0;
			ioctl_file_ext <= '0;
			addr           <= '0;
			wr_pend        <= 1'b0;
		end else begin
			ioctl_wr <= wr_pend;
			wr_pend  <= 1'b0;

			if (frame.data_stb) begin
				case (frame.cmd)
					// extension comes high half first
					cmd_file_info: begin
						if (frame.word_idx == 1)
							ioctl_file_ext[31:16] <= frame.word.raw;
						else if (frame.word_idx == 2)
							ioctl_file_ext[15:0] <= frame.word.raw;
					end

					cmd_file_index: ioctl_index <= frame.word.raw[7:0];

					cmd_file_tx: begin
						if (frame.word.raw[7:0] != 8'h00) begin
							addr           <= '0;
							ioctl_download <= 1'b1;
						end else begin
							// final address equals the byte count
							ioctl_addr     <= addr;
							ioctl_download <= 1'b0;
						end
					end

					cmd_file_dat: begin
						ioctl_addr <= addr;
						ioctl_dout <= frame.word.raw;
						wr_pend    <= 1'b1;
						addr       <= addr + ioctl_addr_step;
					end

					default: ;
				endcase
			end
		end
	end

	// back to back writes only come from back to back data words
	a_wr_single: assert property (
		@(posedge clk_sys) disable iff (reset)
		(ioctl_wr && $past(ioctl_wr)) |-> ($past(frame.data_stb, 2) && $past(frame.data_stb, 3))
	);

endmodule

//--- hdl/hps_link.sv
`timescale 1ns/1ps

module hps_link import hps_link_pkg::*; (
	input  logic                    clk_sys,
	input  logic                    reset,

	// host side
	input  logic                    io_enable,
	input  logic                    io_strobe,
	input  logic [io_word_w-1:0]    io_din,
	output logic [io_word_w-1:0]    io_dout,
	output logic                    io_wait,

	// core side
	input  logic                    ioctl_wait,
	input  logic [status_w-1:0]     status_in,
	input  logic                    status_set,
	input  logic [io_word_w-1:0]    status_menumask,
	output logic [1:0]              buttons,
	output logic                    forced_scandoubler,
	output logic                    direct_video,
	output logic [joy_w-1:0]        joystick_0,
	output logic [joy_w-1:0]        joystick_1,
	output logic [joy_w-1:0]        joystick_2,
	output logic [joy_w-1:0]        joystick_3,
	output logic [status_w-1:0]     status,
	output logic [ps2_key_w-1:0]    ps2_key,
	output logic                    ioctl_download,
	output logic [7:0]              ioctl_index,
	output logic                    ioctl_wr,
	output logic [ioctl_addr_w-1:0] ioctl_addr,
	output logic [io_word_w-1:0]    ioctl_dout,
	output logic [31:0]             ioctl_file_ext
);

	// the core's download stall is the only back-pressure to the host
	assign io_wait = ioctl_wait;

	io_frame_if u_frame ();

	io_framer u_framer (
		.clk_sys   (clk_sys),
		.reset     (reset),
		.io_enable (io_enable),
		.io_strobe (io_strobe),
		.io_din    (io_din),
		.frame     (u_frame.framer)
	);

	host_regs u_host_regs (
		.clk_sys            (clk_sys),
		.reset              (reset),
		.frame              (u_frame.sink),
		.status_in          (status_in),
		.status_set         (status_set),
		.status_menumask    (status_menumask),
		.io_dout            (io_dout),
		.buttons            (buttons),
		.forced_scandoubler (forced_scandoubler),
		.direct_video       (direct_video),
		.joystick_0         (joystick_0),
		.joystick_1         (joystick_1),
		.joystick_2         (joystick_2),
		.joystick_3         (joystick_3),
		.status             (status)
	);

	ps2_key_capture u_ps2_key (
		.clk_sys (clk_sys),
		.reset   (reset),
		.frame   (u_frame.sink),
		.ps2_key (ps2_key)
	);

	file_loader u_file_loader (
		.clk_sys        (clk_sys),
		.reset          (reset),
		.frame          (u_frame.sink),
		.ioctl_download (ioctl_download),
		.ioctl_index    (ioctl_index),
		.ioctl_wr       (ioctl_wr),
		.ioctl_addr     (ioctl_addr),
		.ioctl_dout     (ioctl_dout),
		.ioctl_file_ext (ioctl_file_ext)
	);

endmodule

//--- testbench/tb_hps_link.sv
`timescale 1ns/1ps

module tb_hps_link import hps_link_pkg::*;;

	// words sent over all tests, used to size the watchdog
	localparam int total_words = 85;
	localparam int file_words  = 12;

	logic                    clk_sys;
	logic                    reset;
	logic                    io_enable;
	logic                    io_strobe;
	logic [io_word_w-1:0]    io_din;
	logic [io_word_w-1:0]    io_dout;
	logic                    io_wait;
	logic                    ioctl_wait;
	logic [status_w-1:0]     status_in;
	logic                    status_set;
	logic [io_word_w-1:0]    status_menumask;
	logic [1:0]              buttons;
	logic                    forced_scandoubler;
	logic                    direct_video;
	logic [joy_w-1:0]        joystick_0;
	logic [joy_w-1:0]        joystick_1;
	logic [joy_w-1:0]        joystick_2;
	logic [joy_w-1:0]        joystick_3;
	logic [status_w-1:0]     status;
	logic [ps2_key_w-1:0]    ps2_key;
	logic                    ioctl_download;
	logic [7:0]              ioctl_index;
	logic                    ioctl_wr;
	logic [ioctl_addr_w-1:0] ioctl_addr;
	logic [io_word_w-1:0]    ioctl_dout;
	logic [31:0]             ioctl_file_ext;

	// data words of the next frame (index 1 up) and the words read back
	logic [io_word_w-1:0] dat [0:63];
	logic [io_word_w-1:0] rdbk [0:63];
	logic [ps2_key_w-1:0] exp_key;
	integer               seed;
	logic                 wait_rand;
	int                   wr_count;
	int                   errors;
	int                   tests_run;
	int                   tests_failed;

	hps_link u_dut (.*);

	always #2 clk_sys = ~clk_sys;

	////////////////////////////////////////////////////////////////////////////
	// compare tasks
	////////////////////////////////////////////////////////////////////////////

	task automatic check_word(input string what, input logic [io_word_w-1:0] got,
			input logic [io_word_w-1:0] exp);
		if (got !== exp) begin
			errors++;
			$display("error @ %0t ns: %s is %h, expected %h", $time, what, got, exp);
		end
	endtask

	task automatic check_joy(input string what, input logic [joy_w-1:0] got,
			input logic [joy_w-1:0] exp);
		if (got !== exp) begin
			errors++;
			$display("error @ %0t ns: %s is %h, expected %h", $time, what, got, exp);
		end
	endtask

	task automatic check_status(input string what, input logic [status_w-1:0] got,
			input logic [status_w-1:0] exp);
		if (got !== exp) begin
			errors++;
			$display("error @ %0t ns: %s is %h, expected %h", $time, what, got, exp);
		end
	endtask

	task automatic check_key(input string what, input logic [ps2_key_w-1:0] got,
			input logic [ps2_key_w-1:0] exp);
		if (got !== exp) begin
			errors++;
			$display("error @ %0t ns: %s is %h, expected %h", $time, what, got, exp);
		end
	endtask

	task automatic check_addr(input string what, input logic [ioctl_addr_w-1:0] got,
			input logic [ioctl_addr_w-1:0] exp);
		if (got !== exp) begin
			errors++;
			$display("error @ %0t ns: %s is %h, expected %h", $time, what, got, exp);
		end
	endtask

	task automatic check_flag(input string what, input logic got, input logic exp);
		if (got !== exp) begin
			errors++;
			$display("error @ %0t ns: %s is %b, expected %b", $time, what, got, exp);
		end
	endtask

	task automatic end_test(input string name, input int errs_before);
		tests_run++;
		if (errors == errs_before) begin
			$display("%0t ns  %s: passed", $time, name);
		end else begin
			tests_failed++;
			$display("%0t ns  %s: failed, %0d errors", $time, name, errors - errs_before);
		end
	endtask

	////////////////////////////////////////////////////////////////////////////
	// host side
	////////////////////////////////////////////////////////////////////////////

	function automatic logic [io_word_w-1:0] rnd16();
		rnd16 = $random(seed);
	endfunction

	// io_wait is read one cycle after it last changed, then one strobe
	task automatic host_read(input logic [io_word_w-1:0] w, output logic [io_word_w-1:0] rd);
		@(negedge clk_sys);
		check_flag("io_wait", io_wait, ioctl_wait);
		while (io_wait) begin
			if (wait_rand)
				ioctl_wait = $random(seed);
			@(negedge clk_sys);
			check_flag("io_wait", io_wait, ioctl_wait);
		end
		io_strobe = 1'b1;
		io_din    = w;
		@(negedge clk_sys);
		io_strobe = 1'b0;
		rd        = io_dout;
		if (wait_rand)
			ioctl_wait = $random(seed);
	endtask

	task automatic host_frame(input logic [7:0] cmd, input int n);
		io_enable = 1'b1;
		host_read({8'h00, cmd}, rdbk[0]);
		for (int i = 1; i <= n; i++)
			host_read(dat[i], rdbk[i]);
		io_enable = 1'b0;
		// room for frame_end and the key update
		repeat (3) @(negedge clk_sys);
	endtask

	// every write pulse must carry the next address and data word
	always @(negedge clk_sys) begin
		if (!reset && ioctl_wr) begin
			check_addr("ioctl_addr on write", ioctl_addr, 2 * wr_count);
			check_word("ioctl_dout on write", ioctl_dout, dat[wr_count + 1]);
			check_flag("ioctl_download on write", ioctl_download, 1'b1);
			wr_count++;
		end
	end

	////////////////////////////////////////////////////////////////////////////
	// tests
	////////////////////////////////////////////////////////////////////////////

	task automatic test_config();
		int                   e0;
		logic [io_word_w-1:0] cfg_bit [0:3];
		e0 = errors;
		cfg_bit = '{16'h0001, 16'h0002, 16'h0010, 16'h0400};
		check_word("config after reset", {buttons, forced_scandoubler, direct_video}, '0);
		check_word("io_dout after reset", io_dout, '0);
		check_key("ps2_key after reset", ps2_key, '0);
		check_status("status after reset", status, '0);
		check_joy("joystick_0 after reset", joystick_0, '0);
		check_joy("joystick_3 after reset", joystick_3, '0);
		check_flag("ioctl_download after reset", ioctl_download, 1'b0);
		check_flag("ioctl_wr after reset", ioctl_wr, 1'b0);
		check_addr("ioctl_addr after reset", ioctl_addr, '0);
		// one config bit at a time, so a swapped bit shows up
		for (int b = 0; b < 4; b++) begin
			dat[1] = (rnd16() & ~16'h0413) | cfg_bit[b];
			host_frame(cmd_cfg, 1);
			check_word("config bits",
				{5'b0, direct_video, 5'b0, forced_scandoubler, 2'b0, buttons},
				dat[1] & 16'h0413);
		end
		check_word("io_dout after frame", io_dout, '0);
		end_test("configuration", e0);
	endtask

	task automatic test_joy_status();
		int          e0;
		logic [7:0]  joy_cmd [0:3];
		logic [31:0] exp_joy [0:3];
		e0 = errors;
		joy_cmd = '{cmd_joy0, cmd_joy1, cmd_joy2, cmd_joy3};
		exp_joy = '{32'h0, 32'h0, 32'h0, 32'h0};
		for (int j = 0; j < 4; j++) begin
			dat[1] = rnd16();
			dat[2] = rnd16();
			host_frame(joy_cmd[j], 2);
			exp_joy[j] = {dat[2], dat[1]};
			check_joy("joystick_0", joystick_0, exp_joy[0]);
			check_joy("joystick_1", joystick_1, exp_joy[1]);
			check_joy("joystick_2", joystick_2, exp_joy[2]);
			check_joy("joystick_3", joystick_3, exp_joy[3]);
		end
		for (int i = 1; i <= 4; i++)
			dat[i] = rnd16();
		host_frame(cmd_status, 4);
		check_status("status", status, {dat[4], dat[3], dat[2], dat[1]});
		end_test("joysticks and status", e0);
	endtask

	task automatic test_status_req();
		int                  e0;
		logic [status_w-1:0] exp_req;
		e0 = errors;
		repeat (3) begin
			status_in  = {$random(seed), $random(seed)};
			status_set = 1'b1;
			@(negedge clk_sys);
			status_set = 1'b0;
			@(negedge clk_sys);
		end
		// the request stays latched after status_in moves on
		exp_req   = status_in;
		status_in = ~status_in;
		for (int i = 1; i <= 4; i++)
			dat[i] = '0;
		host_frame(cmd_status_req, 4);
		check_word("request tag and count", rdbk[0], 16'h00a3);
		check_status("requested status", {rdbk[4], rdbk[3], rdbk[2], rdbk[1]}, exp_req);
		check_word("io_dout after frame", io_dout, '0);
		status_menumask = rnd16();
		dat[1] = '0;
		host_frame(cmd_menumask, 1);
		check_word("menumask command readback", rdbk[0], '0);
		check_word("menumask readback", rdbk[1], status_menumask);
		end_test("status request", e0);
	endtask

	// sends n scan bytes, oldest in the top byte used
	task automatic key_frame(input logic [31:0] bytes, input int n, input logic [9:0] code);
		for (int i = 1; i <= n; i++)
			dat[i] = {8'h00, bytes[8 * (n - i) +: 8]};
		host_frame(cmd_kbd, n);
		exp_key = {~exp_key[10], code};
		check_key("ps2_key", ps2_key, exp_key);
	endtask

	task automatic test_keyboard();
		int e0;
		e0 = errors;
		key_frame(32'h0000001c, 1, 10'h21c);
		key_frame(32'h0000f01c, 2, 10'h01c);
		key_frame(32'h0000e075, 2, 10'h375);
		key_frame(32'h00e0f075, 3, 10'h175);
		key_frame(32'he012e07c, 4, 10'h37c);
		key_frame(32'h7ce0f012, 4, 10'h17c);
		key_frame(32'hf014f077, 4, 10'h377);
		// a skip word drops the whole event
		dat[1] = 16'h001c;
		dat[2] = 16'hff00;
		dat[3] = 16'h005a;
		host_frame(cmd_kbd, 3);
		check_key("ps2_key after skip", ps2_key, exp_key);
		end_test("keyboard", e0);
	endtask

	task automatic test_download();
		int e0;
		e0 = errors;
		dat[1] = rnd16();
		host_frame(cmd_file_index, 1);
		check_word("ioctl_index", {8'h00, ioctl_index}, {8'h00, dat[1][7:0]});
		dat[1] = rnd16();
		dat[2] = rnd16();
		host_frame(cmd_file_info, 2);
		check_word("ioctl_file_ext high", ioctl_file_ext[31:16], dat[1]);
		check_word("ioctl_file_ext low", ioctl_file_ext[15:0], dat[2]);
		dat[1] = 16'h00ff;
		host_frame(cmd_file_tx, 1);
		check_flag("ioctl_download after start", ioctl_download, 1'b1);
		wr_count = 0;
		for (int i = 1; i <= file_words; i++)
			dat[i] = rnd16();
		wait_rand = 1'b1;
		host_frame(cmd_file_dat, file_words);
		wait_rand  = 1'b0;
		ioctl_wait = 1'b0;
		if (wr_count != file_words) begin
			errors++;
			$display("error @ %0t ns: %0d write pulses, expected %0d", $time, wr_count,
				file_words);
		end
		check_flag("ioctl_download before stop", ioctl_download, 1'b1);
		dat[1] = {rnd16() | 16'h0100} & 16'hff00;
		host_frame(cmd_file_tx, 1);
		check_flag("ioctl_download after stop", ioctl_download, 1'b0);
		check_addr("final ioctl_addr", ioctl_addr, 2 * file_words);
		end_test("download", e0);
	endtask

	////////////////////////////////////////////////////////////////////////////
	// sequence and watchdog
	////////////////////////////////////////////////////////////////////////////

	initial begin
		seed            = 32'h35fbe1f0;
		clk_sys         = 1'b0;
		reset           = 1'b1;
		io_enable       = 1'b0;
		io_strobe       = 1'b0;
		io_din          = '0;
		ioctl_wait      = 1'b0;
		status_in       = '0;
		status_set      = 1'b0;
		status_menumask = '0;
		wait_rand       = 1'b0;
		exp_key         = '0;
		wr_count        = 0;
		errors          = 0;
		tests_run       = 0;
		tests_failed    = 0;
		repeat (5) @(posedge clk_sys);
		@(negedge clk_sys);
		reset = 1'b0;
		test_config();
		test_joy_status();
		test_status_req();
		test_keyboard();
		test_download();
		$display("%0d tests run, %0d failed, %0d errors", tests_run, tests_failed, errors);
		if (errors == 0)
			$display("TEST RESULT: PASS");
		else
			$display("TEST RESULT: FAIL");
		$finish;
	end

	initial begin
		#(total_words * 20 * 4);
		$display("timeout: the tests did not finish in %0d ns", total_words * 20 * 4);
		$display("TEST RESULT: FAIL");
		$finish;
	end

endmodule

//--- hps_link.f
hdl/hps_link_pkg.sv
hdl/io_frame_if.sv
hdl/io_framer.sv
hdl/host_regs.sv
hdl/ps2_key_capture.sv
hdl/file_loader.sv
hdl/hps_link.sv
testbench/tb_hps_link.sv
